// ==== common/rs_defs.svh ====
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

// ====================
// Datapath widths
// ====================

// Operand, PC and store data word
`define RS_DATA_WIDTH 32

// Physical destination register
`define RS_PHYS_REG_WIDTH 6

// Producer tag carried with each operand
`define RS_TAG_WIDTH 3

// ====================
// Control fields
// ====================

`define RS_CTRL_WIDTH 11
`define RS_BRANCH_SEL_WIDTH 3

// ROB index is the low part of the destination register
`define RS_ROB_IDX_WIDTH 5
`define RS_ROB_DEPTH 32

// One bit wider than the index so a full lap still fits
`define RS_DIST_WIDTH 6

`endif

// ==== common/cdb_pkg.sv ====
`default_nettype none

`include "rs_defs.svh"

package cdb_pkg;

    // ====================
    // Common data bus
    // ====================

    // One result slot, valid is a single-cycle strobe
    typedef struct packed {
        logic                           valid;
        logic [`RS_DATA_WIDTH-1:0]      data;
        logic [`RS_PHYS_REG_WIDTH-1:0]  dest_reg;
    } cdb_channel_t;

    // Three ALU slots matched by channel,
    // one load slot matched by destination register
    typedef struct packed {
        cdb_channel_t alu0;
        cdb_channel_t alu1;
        cdb_channel_t alu2;
        cdb_channel_t load;
    } cdb_bus_t;

endpackage

`default_nettype wire

// ==== common/rs_pkg.sv ====
`default_nettype none

`include "rs_defs.svh"

package rs_pkg;

    // Producer an operand is waiting on
    typedef enum logic [`RS_TAG_WIDTH-1:0] {
        tag_alu0  = 3'd0,
        tag_alu1  = 3'd1,
        tag_alu2  = 3'd2,
        tag_load  = 3'd3,
        tag_ready = 3'd7
    } rs_tag_e;

    // Load view of an operand word, awaited register in the low bits
    typedef struct packed {
        logic [`RS_DATA_WIDTH-`RS_PHYS_REG_WIDTH-1:0] pad;
        logic [`RS_PHYS_REG_WIDTH-1:0]                phys_reg;
    } rs_load_ref_t;

    // Data word, or awaited register when the tag is tag_load
    typedef union packed {
        logic [`RS_DATA_WIDTH-1:0] data;
        rs_load_ref_t              load;
    } rs_operand_word_u;

    typedef struct packed {
        rs_tag_e          tag;
        rs_operand_word_u word;
    } rs_operand_t;

    // ====================
    // Instruction words
    // ====================

    typedef struct packed {
        logic [`RS_CTRL_WIDTH-1:0]       control_signals;
        logic [`RS_DATA_WIDTH-1:0]       pc;
        logic [`RS_PHYS_REG_WIDTH-1:0]   rd_phys_addr;
        logic [`RS_DATA_WIDTH-1:0]       pc_at_prediction;
        logic [`RS_BRANCH_SEL_WIDTH-1:0] branch_sel;
        logic                            branch_prediction;
        logic [`RS_DATA_WIDTH-1:0]       store_data;
    } rs_context_t;

    typedef struct packed {
        rs_context_t ctx;
        rs_operand_t op_a;
        rs_operand_t op_b;
    } rs_dispatch_t;

    typedef struct packed {
        rs_context_t               ctx;
        logic [`RS_DATA_WIDTH-1:0] data_a;
        logic [`RS_DATA_WIDTH-1:0] data_b;
    } rs_issue_t;

    // Eager misprediction, misprediction bit is a one-cycle strobe
    typedef struct packed {
        logic                         misprediction;
        logic [`RS_DIST_WIDTH-1:0]    mispredicted_distance;
        logic [`RS_ROB_IDX_WIDTH-1:0] rob_head_ptr;
    } rs_flush_t;

endpackage

`default_nettype wire

// ==== reservation_station/operand_capture.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rs_defs.svh"

module operand_capture
    import rs_pkg::*;
    import cdb_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      occupied,
    input  logic                      capture_en,
    input  logic                      release_en,
    input  rs_operand_t               dispatch_operand,
    input  cdb_bus_t                  cdb,
    output logic                      operand_ready,
    output logic [`RS_DATA_WIDTH-1:0] operand_value
);

    rs_tag_e                   held_tag;
    rs_operand_word_u          held_word;
    logic                      cdb_hit;
    logic [`RS_DATA_WIDTH-1:0] cdb_data;

    // ====================
    // CDB match
    // ====================

    // ALU slots match on channel, the load slot on the awaited register
    always_comb begin
        cdb_hit  = 1'b0;
        cdb_data = cdb.load.data;
        case (held_tag)
            tag_alu0: begin
                cdb_hit  = cdb.alu0.valid;
                cdb_data = cdb.alu0.data;
            end
            tag_alu1: begin
                cdb_hit  = cdb.alu1.valid;
                cdb_data = cdb.alu1.data;
            end
            tag_alu2: begin
                cdb_hit  = cdb.alu2.valid;
                cdb_data = cdb.alu2.data;
            end
            tag_load: begin
                cdb_hit = cdb.load.valid && (cdb.load.dest_reg == held_word.load.phys_reg);
            end
            default: cdb_hit = 1'b0;
        endcase
    end

    // Idle entry reports the dispatch operand as is
    assign operand_ready = occupied ? ((held_tag == tag_ready) || cdb_hit)
                                    : (dispatch_operand.tag == tag_ready);
    assign operand_value = !occupied                ? dispatch_operand.word.data :
                           (held_tag == tag_ready)  ? held_word.data : cdb_data;

    // Tag back to a waiting code once the entry leaves
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            held_tag <= tag_alu0;
        end else if (release_en) begin
            held_tag <= tag_alu0;
        end else if (capture_en) begin
            held_tag <= dispatch_operand.tag;
        end else if (occupied && cdb_hit) begin
            held_tag <= tag_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture_en) begin
            held_word <= dispatch_operand.word;
        end else if (occupied && cdb_hit) begin
            held_word.data <= cdb_data;
        end
    end

    // Resolved value must not be overwritten by a later broadcast
    held_value_stable: assert property (@(posedge clk) disable iff (!reset)
        occupied && (held_tag == tag_ready) && !release_en |=> $stable(held_word.data));

endmodule

`default_nettype wire

// ==== reservation_station/issue_control.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rs_defs.svh"

module issue_control
    import rs_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      dispatch_valid,
    input  rs_context_t               dispatch_ctx,
    input  logic                      issue_ready,
    input  rs_flush_t                 flush,
    input  logic                      a_ready,
    input  logic                      b_ready,
    input  logic [`RS_DATA_WIDTH-1:0] a_value,
    input  logic [`RS_DATA_WIDTH-1:0] b_value,
    output logic                      dispatch_ready,
    output logic                      occupied,
    output logic                      capture_en,
    output logic                      release_en,
    output logic                      issue_valid,
    output rs_issue_t                 issue
);

    localparam logic [`RS_DIST_WIDTH-1:0] ROB_DEPTH = `RS_ROB_DEPTH;

    rs_context_t                  held_ctx;
    logic [`RS_ROB_IDX_WIDTH-1:0] held_rob_idx;
    logic [`RS_DIST_WIDTH-1:0]    idx_ext;
    logic [`RS_DIST_WIDTH-1:0]    head_ext;
    logic [`RS_DIST_WIDTH-1:0]    rob_distance;
    logic                         flush_hit;
    logic                         both_ready;
    logic                         direct_issue;
    logic                         held_issue;
    logic                         issue_fire;

    // ====================
    // Eager flush
    // ====================

    assign held_rob_idx = held_ctx.rd_phys_addr[`RS_ROB_IDX_WIDTH-1:0];
    assign idx_ext      = {1'b0, held_rob_idx};
    assign head_ext     = {1'b0, flush.rob_head_ptr};

    // Distance from the ROB head, wrapping around the buffer
    always_comb begin
        if (idx_ext >= head_ext) begin
            rob_distance = idx_ext - head_ext;
        end else begin
            rob_distance = ROB_DEPTH - head_ext + idx_ext;
        end
    end

    // Younger than the mispredicted branch means wrong path
    assign flush_hit = occupied && flush.misprediction
                       && (rob_distance > flush.mispredicted_distance);

    // ====================
    // Issue decision
    // ====================

    // Operand readiness already follows dispatch when idle
    assign both_ready   = a_ready && b_ready;
    assign direct_issue = dispatch_valid && !occupied && both_ready && issue_ready;
    assign held_issue   = occupied && both_ready && issue_ready && !flush_hit;
    assign issue_fire   = direct_issue || held_issue;

    // Anything accepted that cannot go out right now is stored
    assign capture_en     = dispatch_valid && !occupied && !(both_ready && issue_ready);
    assign release_en     = held_issue || flush_hit;
    assign dispatch_ready = !occupied;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            occupied <= 1'b0;
        end else if (capture_en) begin
            occupied <= 1'b1;
        end else if (release_en) begin
            occupied <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture_en) begin
            held_ctx <= dispatch_ctx;
        end
    end

    // One execute pulse per instruction
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= issue_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            issue.ctx    <= occupied ? held_ctx : dispatch_ctx;
            issue.data_a <= a_value;
            issue.data_b <= b_value;
        end
    end

    // Nothing is captured over a held entry
    capture_when_free: assert property (@(posedge clk) disable iff (!reset)
        occupied |-> !capture_en);

    // Dropped entry never reaches execute
    no_issue_after_flush: assert property (@(posedge clk) disable iff (!reset)
        flush_hit |=> !issue_valid);

endmodule

`default_nettype wire

// ==== design/reservation_station.sv ====
`default_nettype none
`timescale 1ns/10ps

module reservation_station
    import rs_pkg::*;
    import cdb_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         dispatch_valid,
    input  rs_dispatch_t dispatch,
    output logic         dispatch_ready,
    output logic         issue_valid,
    output rs_issue_t    issue,
    input  logic         issue_ready,
    input  cdb_bus_t     cdb,
    input  rs_flush_t    flush
);

    logic        occupied;
    logic        capture_en;
    logic        release_en;
    logic        a_ready;
    logic        b_ready;
    logic [31:0] a_value;
    logic [31:0] b_value;

    // Two operands watch the CDB side by side
    operand_capture op_a (
        .clk              (clk),
        .reset            (reset),
        .occupied         (occupied),
        .capture_en       (capture_en),
        .release_en       (release_en),
        .dispatch_operand (dispatch.op_a),
        .cdb              (cdb),
        .operand_ready    (a_ready),
        .operand_value    (a_value)
    );

    operand_capture op_b (
        .clk              (clk),
        .reset            (reset),
        .occupied         (occupied),
        .capture_en       (capture_en),
        .release_en       (release_en),
        .dispatch_operand (dispatch.op_b),
        .cdb              (cdb),
        .operand_ready    (b_ready),
        .operand_value    (b_value)
    );

    issue_control ctrl0 (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ctx   (dispatch.ctx),
        .issue_ready    (issue_ready),
        .flush          (flush),
        .a_ready        (a_ready),
        .b_ready        (b_ready),
        .a_value        (a_value),
        .b_value        (b_value),
        .dispatch_ready (dispatch_ready),
        .occupied       (occupied),
        .capture_en     (capture_en),
        .release_en     (release_en),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

endmodule

`default_nettype wire

// ==== tests/rs_vectors.svh ====
`ifndef RS_VECTORS_SVH
`define RS_VECTORS_SVH

// Columns: tag_a reg_a tag_b reg_b rd_phys | ev0 chan dest delay | ev1 chan dest delay
//          ready_low | flush delay dist head | exp_cycle src_a src_b

localparam logic [2:0] CH_ALU0 = 3'd0;
localparam logic [2:0] CH_ALU1 = 3'd1;
localparam logic [2:0] CH_ALU2 = 3'd2;
localparam logic [2:0] CH_LOAD = 3'd3;
localparam logic [2:0] CH_NONE = 3'd7;

// Where the expected operand value comes from
localparam logic [1:0] SRC_WORD = 2'd0;
localparam logic [1:0] SRC_EV0  = 2'd1;
localparam logic [1:0] SRC_EV1  = 2'd2;

localparam int NUM_VECTORS = 10;

typedef struct packed {
    rs_tag_e    tag_a;
    logic [5:0] reg_a;
    rs_tag_e    tag_b;
    logic [5:0] reg_b;
    logic [5:0] rd_phys;
    logic [2:0] ev0_chan;
    logic [5:0] ev0_dest;
    logic [4:0] ev0_delay;
    logic [2:0] ev1_chan;
    logic [5:0] ev1_dest;
    logic [4:0] ev1_delay;
    logic [4:0] ready_low;
    logic [4:0] flush_delay;
    logic [5:0] flush_dist;
    logic [4:0] flush_head;
    logic [4:0] exp_cycle;
    logic [1:0] src_a;
    logic [1:0] src_b;
} vector_t;

vector_t vectors [NUM_VECTORS];

task automatic load_vectors();
    // Direct issue, then ALU wake-up with a strobe on the wrong channel first
    vectors[0] = '{tag_ready, 6'd0, tag_ready, 6'd0, 6'd1, CH_NONE, 6'd0, 5'd0,
                   CH_NONE, 6'd0, 5'd0, 5'd0, 5'd0, 6'd0, 5'd0, 5'd1, SRC_WORD, SRC_WORD};
    vectors[1] = '{tag_alu1, 6'd0, tag_ready, 6'd0, 6'd2, CH_ALU0, 6'd0, 5'd1,
                   CH_ALU1, 6'd0, 5'd3, 5'd0, 5'd0, 6'd0, 5'd0, 5'd4, SRC_EV1, SRC_WORD};
    vectors[2] = '{tag_ready, 6'd0, tag_alu2, 6'd0, 6'd3, CH_ALU2, 6'd0, 5'd2,
                   CH_NONE, 6'd0, 5'd0, 5'd0, 5'd0, 6'd0, 5'd0, 5'd3, SRC_WORD, SRC_EV0};
    // Load match by register, and two channels in one cycle
    vectors[3] = '{tag_load, 6'd12, tag_ready, 6'd0, 6'd4, CH_LOAD, 6'd13, 5'd1,
                   CH_LOAD, 6'd12, 5'd3, 5'd0, 5'd0, 6'd0, 5'd0, 5'd4, SRC_EV1, SRC_WORD};
    vectors[4] = '{tag_alu2, 6'd0, tag_load, 6'd9, 6'd5, CH_ALU2, 6'd0, 5'd2,
                   CH_LOAD, 6'd9, 5'd2, 5'd0, 5'd0, 6'd0, 5'd0, 5'd3, SRC_EV0, SRC_EV1};
    // Back-pressure on a ready and on a waiting dispatch
    vectors[5] = '{tag_ready, 6'd0, tag_ready, 6'd0, 6'd6, CH_NONE, 6'd0, 5'd0,
                   CH_NONE, 6'd0, 5'd0, 5'd3, 5'd0, 6'd0, 5'd0, 5'd4, SRC_WORD, SRC_WORD};
    vectors[6] = '{tag_alu0, 6'd0, tag_ready, 6'd0, 6'd7, CH_ALU0, 6'd0, 5'd1,
                   CH_NONE, 6'd0, 5'd0, 5'd4, 5'd0, 6'd0, 5'd0, 5'd5, SRC_EV0, SRC_WORD};
    // Flush drops, flush at equal distance survives, flush across the ROB wrap
    vectors[7] = '{tag_alu0, 6'd0, tag_ready, 6'd0, 6'd20, CH_ALU0, 6'd0, 5'd4,
                   CH_NONE, 6'd0, 5'd0, 5'd0, 5'd2, 6'd10, 5'd4, 5'd0, SRC_WORD, SRC_WORD};
    vectors[8] = '{tag_alu1, 6'd0, tag_ready, 6'd0, 6'd3, CH_ALU1, 6'd0, 5'd4,
                   CH_NONE, 6'd0, 5'd0, 5'd0, 5'd2, 6'd5, 5'd30, 5'd5, SRC_EV0, SRC_WORD};
    vectors[9] = '{tag_ready, 6'd0, tag_load, 6'd40, 6'd2, CH_LOAD, 6'd40, 5'd5,
                   CH_NONE, 6'd0, 5'd0, 5'd0, 5'd3, 6'd3, 5'd28, 5'd0, SRC_WORD, SRC_WORD};
endtask

`endif

// ==== tests/rs_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rs_defs.svh"

module rs_tb
    import rs_pkg::*;
    import cdb_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int ROW_CYCLES = 20;

    logic         clk;
    logic         reset;
    logic         dispatch_valid;
    rs_dispatch_t dispatch;
    logic         dispatch_ready;
    logic         issue_valid;
    rs_issue_t    issue;
    logic         issue_ready;
    cdb_bus_t     cdb;
    rs_flush_t    flush;

    `include "rs_vectors.svh"

    logic [31:0]               lcg_state;
    logic [`RS_DATA_WIDTH-1:0] word_a  [NUM_VECTORS];
    logic [`RS_DATA_WIDTH-1:0] word_b  [NUM_VECTORS];
    logic [`RS_DATA_WIDTH-1:0] ev_data [NUM_VECTORS][2];
    rs_context_t               ctx_tab [NUM_VECTORS];
    int                        error_count;
    int                        check_count;

    reservation_station dut0 (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .issue_ready    (issue_ready),
        .cdb            (cdb),
        .flush          (flush)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_VECTORS * 40 + 16) * CLK_PERIOD);
        $display("Watchdog expired before all scenarios finished");
        $display("Simulation failed");
        $finish;
    end

    // ====================
    // Stimulus helpers
    // ====================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic fill_random_fields();
        for (int i = 0; i < NUM_VECTORS; i++) begin
            // Load view carries the awaited register, zero padded
            word_a[i] = (vectors[i].tag_a == tag_load) ? 32'(vectors[i].reg_a) : lcg_next();
            word_b[i] = (vectors[i].tag_b == tag_load) ? 32'(vectors[i].reg_b) : lcg_next();
            ev_data[i][0] = lcg_next();
            ev_data[i][1] = lcg_next();
            ctx_tab[i].control_signals   = 11'(lcg_next());
            ctx_tab[i].pc                = lcg_next();
            ctx_tab[i].rd_phys_addr      = vectors[i].rd_phys;
            ctx_tab[i].pc_at_prediction  = lcg_next();
            ctx_tab[i].branch_sel        = 3'(lcg_next());
            ctx_tab[i].branch_prediction = 1'(lcg_next());
            ctx_tab[i].store_data        = lcg_next();
        end
    endtask

    function automatic rs_dispatch_t build_dispatch(int idx);
        rs_dispatch_t d;
        d.ctx            = ctx_tab[idx];
        d.op_a.tag       = vectors[idx].tag_a;
        d.op_a.word.data = word_a[idx];
        d.op_b.tag       = vectors[idx].tag_b;
        d.op_b.word.data = word_b[idx];
        return d;
    endfunction

    function automatic logic [31:0] pick_data(logic [1:0] src, logic [31:0] word, int idx);
        case (src)
            SRC_EV0: return ev_data[idx][0];
            SRC_EV1: return ev_data[idx][1];
            default: return word;
        endcase
    endfunction

    function automatic cdb_bus_t cdb_for_cycle(int idx, int cyc);
        cdb_bus_t     bus;
        cdb_channel_t ch;
        logic [2:0]   chan;
        logic [4:0]   delay;
        bus = '0;
        for (int e = 0; e < 2; e++) begin
            ch.valid    = 1'b1;
            ch.data     = ev_data[idx][e];
            ch.dest_reg = (e == 0) ? vectors[idx].ev0_dest : vectors[idx].ev1_dest;
            chan        = (e == 0) ? vectors[idx].ev0_chan : vectors[idx].ev1_chan;
            delay       = (e == 0) ? vectors[idx].ev0_delay : vectors[idx].ev1_delay;
            if (delay == cyc) begin
                case (chan)
                    CH_ALU0: bus.alu0 = ch;
                    CH_ALU1: bus.alu1 = ch;
                    CH_ALU2: bus.alu2 = ch;
                    CH_LOAD: bus.load = ch;
                    default: ;
                endcase
            end
        end
        return bus;
    endfunction

    function automatic rs_flush_t flush_for_cycle(int idx, int cyc);
        rs_flush_t f;
        f = '0;
        if (vectors[idx].flush_delay != 0 && vectors[idx].flush_delay == cyc) begin
            f.misprediction         = 1'b1;
            f.mispredicted_distance = vectors[idx].flush_dist;
            f.rob_head_ptr          = vectors[idx].flush_head;
        end
        return f;
    endfunction

    task automatic compare_value(input string name, input logic [255:0] expected,
                                 input logic [255:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // ====================
    // Scenario runner
    // ====================

    task automatic run_vector(input int idx);
        vector_t     v;
        int          cyc;
        int          issue_cycle;
        int          end_cycle;
        logic        direct;
        logic        exp_ready;
        logic [31:0] exp_a;
        logic [31:0] exp_b;
        v           = vectors[idx];
        cyc         = 0;
        issue_cycle = -1;
        direct      = (v.tag_a == tag_ready) && (v.tag_b == tag_ready) && (v.ready_low == 0);
        // Entry frees on issue, or the cycle after a dropping flush
        end_cycle   = (v.exp_cycle != 0) ? int'(v.exp_cycle) : int'(v.flush_delay) + 1;
        exp_a       = pick_data(v.src_a, word_a[idx], idx);
        exp_b       = pick_data(v.src_b, word_b[idx], idx);
        @(posedge clk);
        dispatch_valid <= 1'b1;
        dispatch       <= build_dispatch(idx);
        issue_ready    <= (v.ready_low == 0);
        cdb            <= '0;
        flush          <= '0;
        while (cyc < ROW_CYCLES && (issue_cycle < 0 || cyc <= issue_cycle + 2)) begin
            @(negedge clk);
            exp_ready = direct || (cyc == 0) || (cyc >= end_cycle);
            compare_value("dispatch_ready", 256'(exp_ready), 256'(dispatch_ready));
            if (issue_valid === 1'b1) begin
                if (issue_cycle >= 0) begin
                    error_count++;
                    $display("Row %0d: a second issue_valid pulse came at cycle %0d", idx, cyc);
                end else if (v.exp_cycle == 0) begin
                    error_count++;
                    issue_cycle = cyc;
                    $display("Row %0d: the flushed entry was issued at cycle %0d", idx, cyc);
                end else begin
                    issue_cycle = cyc;
                    compare_value("issue_valid cycle", 256'(v.exp_cycle), 256'(cyc));
                    compare_value("issue.ctx", 256'(ctx_tab[idx]), 256'(issue.ctx));
                    compare_value("issue.data_a", 256'(exp_a), 256'(issue.data_a));
                    compare_value("issue.data_b", 256'(exp_b), 256'(issue.data_b));
                end
            end
            @(posedge clk);
            cyc++;
            dispatch_valid <= 1'b0;
            issue_ready    <= (cyc >= v.ready_low);
            cdb            <= cdb_for_cycle(idx, cyc);
            flush          <= flush_for_cycle(idx, cyc);
        end
        if (v.exp_cycle != 0 && issue_cycle < 0) begin
            error_count++;
            $display("Row %0d: no issue_valid within %0d cycles", idx, ROW_CYCLES);
        end
    endtask

    initial begin
        dispatch_valid = 1'b0;
        dispatch       = '0;
        issue_ready    = 1'b0;
        cdb            = '0;
        flush          = '0;
        reset          = 1'b0;
        error_count    = 0;
        check_count    = 0;
        lcg_state      = 32'd75480;
        load_vectors();
        fill_random_fields();
        repeat (16) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        compare_value("issue_valid", 256'(1'b0), 256'(issue_valid));
        compare_value("dispatch_ready", 256'(1'b1), 256'(dispatch_ready));
        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_vector(i);
        end
        $display("Checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+common
+incdir+tests
common/cdb_pkg.sv
common/rs_pkg.sv
reservation_station/operand_capture.sv
reservation_station/issue_control.sv
design/reservation_station.sv
tests/rs_tb.sv
